/* build.f */
+incdir+.
rv_isa_pkg.sv
issue_pkg.sv
instr_decoder.sv
issue_control.sv
unit_operand_prep.sv
decode_issue.sv
tb_decode_issue.sv

/* tb_decode_issue.sv */
////////////////////////////////////////////////////////////////////////////
// Random-instruction testbench for the decode and issue stage.
// Register data is a fixed function of the register address.
// Busy and not-ready runs are capped at 4 cycles, so held work drains.
////////////////////////////////////////////////////////////////////////////

`include "rv_decode_defs.svh"

module tb_decode_issue
    import rv_isa_pkg::*;
    import issue_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TOTAL_INSTR = 800;
    localparam int CYCLE_LIMIT = TOTAL_INSTR * 10 + 100;

    logic           clk = 1'b0;
    logic           rst;
    logic           flush;
    decode_packet_t decode;
    word_t          rs_data [2];
    logic           rs_busy [2];
    id_t            rs2_busy_id;
    unit_vec_t      unit_ready;
    logic           decode_advance;
    issue_packet_t  issue;
    unit_vec_t      new_request;
    id_t            issue_id;
    alu_inputs_t    alu_inputs;
    ls_inputs_t     ls_inputs;
    branch_inputs_t branch_inputs;

    // Model copy of the issue stage
    logic           m_valid;
    word_t          m_pc;
    word_t          m_instr;
    id_t            m_id;
    decode_packet_t pend;
    opcode_t        kinds [9];
    int             stall_run [5];
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;

    decode_issue dut_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles with instructions still pending", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic word_t reg_value(input reg_addr_t a);
        return (32'(a) + 32'd1) * 32'h9e37_79b9;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Random legal instruction of one of the nine opcodes
    function automatic word_t make_instr();
        word_t w;
        opcode_t opc;
        fn3_t f3;
        w = $urandom;
        opc = kinds[$urandom_range(0, 8)];
        f3 = w[14:12];
        case (opc)
            OPC_JALR:   f3 = 3'b000;
            OPC_LOAD:   f3 = (f3 inside {3'b011, 3'b110, 3'b111}) ? 3'b100 : f3;
            OPC_STORE:  f3 = {1'b0, f3[1], f3[0] & ~f3[1]};
            OPC_BRANCH: f3[1] = f3[1] & f3[2];
            default:    f3 = f3;
        endcase
        w[14:12] = f3;
        // Link registers now and then for calls and returns
        if ($urandom_range(0, 3) == 0) begin
            w[11:7]  = w[20] ? 5'd1 : 5'd5;
            w[19:15] = w[21] ? 5'd1 : 5'd5;
        end
        // funct7 stays zero apart from SUB, SRA and SRAI
        if (opc == OPC_OP || (opc == OPC_OP_IMM && f3[1:0] == 2'b01)) begin
            w[31:25] = {1'b0, w[30] & (f3 inside {3'b000, 3'b101}), 5'b0};
        end
        return {w[31:7], opc, 2'b11};
    endfunction

    task automatic new_packet();
        pend.valid = 1'b1;
        pend.pc = $urandom & 32'hffff_fffc;
        pend.instruction = make_instr();
        pend.id = pend.id + 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Expected unit inputs from the RV32I formats

    task automatic check_issue();
        opcode_t opc;
        fn3_t f3;
        word_t v1;
        word_t v2;
        word_t e1;
        word_t e2;
        logic alu_op;
        logic shift;
        logic slt;
        logic rd_link;
        logic rs1_link;
        opc = opcode_t'(m_instr[6:2]);
        f3 = m_instr[14:12];
        v1 = reg_value(m_instr[19:15]);
        v2 = reg_value(m_instr[24:20]);
        alu_op = opc inside {OPC_OP, OPC_OP_IMM};
        shift = alu_op && (f3 inside {FN3_SLL, FN3_SRL_SRA});
        slt = alu_op && (f3 inside {FN3_SLT, FN3_SLTU});
        rd_link = m_instr[11:7] inside {5'd1, 5'd5};
        rs1_link = m_instr[19:15] inside {5'd1, 5'd5};
        e1 = (opc == OPC_LUI) ? 32'h0 : alu_op ? v1 : m_pc;
        e2 = (opc inside {OPC_LUI, OPC_AUIPC}) ? {m_instr[31:12], 12'h0} :
            (opc == OPC_OP) ? v2 :
            (opc == OPC_OP_IMM) ? {{20{m_instr[31]}}, m_instr[31:20]} : 32'd4;
        compare("issue_id", issue_id, m_id);
        if (!(opc inside {OPC_BRANCH, OPC_LOAD, OPC_STORE})) begin
            compare("alu_inputs.in1", alu_inputs.in1[31:0], e1);
            compare("alu_inputs.in2", alu_inputs.in2[31:0], e2);
            if (slt) begin
                compare("alu_inputs.in1[32]", alu_inputs.in1[32], e1[31] & (f3 == FN3_SLT));
                compare("alu_inputs.in2[32]", alu_inputs.in2[32], e2[31] & (f3 == FN3_SLT));
            end
            compare("alu_inputs.subtract", alu_inputs.subtract,
                slt || (opc == OPC_OP && f3 == FN3_ADD_SUB && m_instr[30]));
            compare("alu_inputs.logic_op", alu_inputs.logic_op, !alu_op ? ALU_LOGIC_ADD :
                (f3 == FN3_XOR) ? ALU_LOGIC_XOR : (f3 == FN3_OR) ? ALU_LOGIC_OR :
                (f3 == FN3_AND) ? ALU_LOGIC_AND : ALU_LOGIC_ADD);
            compare("alu_inputs.slt_path", alu_inputs.slt_path, slt);
            compare("alu_inputs.shifter_path", alu_inputs.shifter_path, shift);
            if (shift) begin
                compare("alu_inputs.lshift", alu_inputs.lshift, f3 == FN3_SLL);
                compare("alu_inputs.shifter_in", alu_inputs.shifter_in, v1);
                compare("alu_inputs.shift_amount", alu_inputs.shift_amount,
                    (opc == OPC_OP) ? v2[4:0] : m_instr[24:20]);
                compare("alu_inputs.arith", alu_inputs.arith, m_instr[30] & v1[31]);
            end
        end
        if (opc inside {OPC_LOAD, OPC_STORE}) begin
            compare("ls_inputs.offset", ls_inputs.offset, (opc == OPC_STORE) ?
                {m_instr[31:25], m_instr[11:7]} : m_instr[31:20]);
            compare("ls_inputs.load", ls_inputs.load, opc == OPC_LOAD);
            compare("ls_inputs.store", ls_inputs.store, opc == OPC_STORE);
            compare("ls_inputs.fn3", ls_inputs.fn3, f3);
            compare("ls_inputs.rs1", ls_inputs.rs1, v1);
            compare("ls_inputs.forwarded_store", ls_inputs.forwarded_store,
                opc == OPC_STORE && rs_busy[1]);
            if (opc == OPC_STORE) begin
                compare("ls_inputs.rs2", ls_inputs.rs2, v2);
                if (rs_busy[1]) begin
                    compare("ls_inputs.store_forward_id", ls_inputs.store_forward_id,
                        rs2_busy_id);
                end
            end
        end
        if (opc inside {OPC_BRANCH, OPC_JAL, OPC_JALR}) begin
            compare("branch_inputs.pc_offset", branch_inputs.pc_offset,
                (opc == OPC_JALR) ? {{9{m_instr[31]}}, m_instr[31:20]} :
                (opc == OPC_JAL) ?
                {m_instr[31], m_instr[19:12], m_instr[20], m_instr[30:21], 1'b0} :
                {{9{m_instr[31]}}, m_instr[7], m_instr[30:25], m_instr[11:8], 1'b0});
            compare("branch_inputs.issue_pc", branch_inputs.issue_pc, m_pc);
            compare("branch_inputs.jal", branch_inputs.jal, opc == OPC_JAL);
            compare("branch_inputs.jalr", branch_inputs.jalr, opc == OPC_JALR);
            compare("branch_inputs.is_call", branch_inputs.is_call,
                opc != OPC_BRANCH && rd_link);
            compare("branch_inputs.is_return", branch_inputs.is_return, opc == OPC_JALR &&
                rs1_link && !(rd_link && m_instr[19:15] == m_instr[11:7]));
            if (opc != OPC_JAL) begin
                compare("branch_inputs.rs1", branch_inputs.rs1, v1);
            end
            if (opc == OPC_BRANCH) begin
                compare("branch_inputs.rs2", branch_inputs.rs2, v2);
                compare("branch_inputs.fn3", branch_inputs.fn3, f3);
                // BLTU and BGEU are the only encodings with fn3[1] set
                compare("branch_inputs.use_signed", branch_inputs.use_signed, !f3[1]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One test of random traffic until count packets are accepted and drained

    task automatic run_phase(input string name, input int count, input int stall_pct,
                             input int flush_pct);
        int accepted;
        int issued;
        int discarded;
        int errors_before;
        int i;
        logic [4:0] stall_vec;
        unit_vec_t units;
        opcode_t opc;
        logic use1;
        logic use2;
        logic ops_ok;
        logic go;
        logic adv;
        accepted = 0;
        issued = 0;
        discarded = 0;
        errors_before = errors;
        while (accepted < count || m_valid) begin
            @(posedge clk);
            #2;
            decode = pend;
            decode.valid = (accepted < count) && ($urandom_range(0, 99) < 70);
            for (i = 0; i < 5; i++) begin
                stall_vec[i] = (stall_run[i] < 4) && ($urandom_range(0, 99) < stall_pct);
                stall_run[i] = stall_vec[i] ? stall_run[i] + 1 : 0;
            end
            rs_busy[0] = stall_vec[0];
            rs_busy[1] = stall_vec[1];
            unit_ready = ~stall_vec[4:2];
            flush = $urandom_range(0, 99) < flush_pct;
            rs2_busy_id = id_t'($urandom);
            rs_data[0] = reg_value(m_instr[19:15]);
            rs_data[1] = reg_value(m_instr[24:20]);
            @(negedge clk);
            opc = opcode_t'(m_instr[6:2]);
            units[`UNIT_ALU] = !(opc inside {OPC_BRANCH, OPC_LOAD, OPC_STORE});
            units[`UNIT_BRANCH] = opc inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
            units[`UNIT_LS] = opc inside {OPC_LOAD, OPC_STORE};
            use1 = !(opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL});
            use2 = opc inside {OPC_BRANCH, OPC_STORE, OPC_OP};
            // Load/store waits only for its base register
            ops_ok = !(rs_busy[0] && use1) &&
                (opc inside {OPC_LOAD, OPC_STORE} || !(rs_busy[1] && use2));
            go = m_valid && !flush && ((units & unit_ready) == units) && ops_ok;
            adv = decode.valid && (!m_valid || go);
            compare("issue.stage_valid", issue.stage_valid, m_valid);
            compare("decode_advance", decode_advance, adv);
            compare("new_request", new_request, go ? units : 3'b000);
            if (m_valid) begin
                compare("issue.pc", issue.pc, m_pc);
                compare("issue.instruction", issue.instruction, m_instr);
                compare("issue.id", issue.id, m_id);
                compare("issue.fn3", issue.fn3, m_instr[14:12]);
                compare("issue.opcode", issue.opcode, opc);
                compare("issue.rs1_addr", issue.rs1_addr, m_instr[19:15]);
                compare("issue.rs2_addr", issue.rs2_addr, m_instr[24:20]);
                compare("issue.rd_addr", issue.rd_addr, m_instr[11:7]);
                compare("issue.uses_rs1", issue.uses_rs1, use1);
                compare("issue.uses_rs2", issue.uses_rs2, use2);
                compare("issue.uses_rd", issue.uses_rd,
                    !(opc inside {OPC_BRANCH, OPC_STORE}));
                compare("issue.units", issue.units, units);
            end
            if (go) begin
                check_issue();
                issued++;
            end
            if (flush) begin
                discarded += int'(m_valid) + int'(adv);
                m_valid = 1'b0;
            end else if (!m_valid || go) begin
                m_valid = decode.valid;
                m_pc = decode.pc;
                m_instr = decode.instruction;
                m_id = decode.id;
            end
            if (adv) begin
                accepted++;
                new_packet();
            end
        end
        if (issued + discarded != accepted) begin
            $display("Instructions lost: %0d accepted, but only %0d issued and %0d flushed",
                accepted, issued, discarded);
            errors++;
        end
        $display("Test %s: %0d accepted, %0d issued, %0d flushed, %0d errors",
            name, accepted, issued, discarded, errors - errors_before);
    endtask

    initial begin
        void'($urandom(32'hee3a_c9cf));
        kinds = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE,
                  OPC_OP_IMM, OPC_OP};
        rst = 1'b1;
        flush = 1'b0;
        decode = '0;
        rs_data = '{32'h0, 32'h0};
        rs_busy = '{1'b0, 1'b0};
        rs2_busy_id = '0;
        unit_ready = '1;
        m_valid = 1'b0;
        m_pc = '0;
        m_instr = '0;
        m_id = '0;
        pend = '0;
        stall_run = '{default: 0};
        new_packet();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        compare("issue.stage_valid", issue.stage_valid, 1'b0);
        compare("new_request", new_request, 3'b000);
        compare("decode_advance", decode_advance, 1'b0);
        $display("Test reset: %0d errors", errors);
        run_phase("routing_operands", 300, 10, 0);
        run_phase("back_pressure", 300, 35, 0);
        run_phase("flush", 200, 20, 10);
        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* decode_issue.sv */
////////////////////////////////////////////////////////////////////////////
// Decode and issue stage of an in-order RV32I core.
// Register-file data and busy flags must return in the cycle of the read.
////////////////////////////////////////////////////////////////////////////

`include "rv_decode_defs.svh"

module decode_issue
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  decode_packet_t   decode,
    input  logic [`XLEN-1:0] rs_data [2],
    input  logic             rs_busy [2],
    input  id_t              rs2_busy_id,
    input  unit_vec_t        unit_ready,
    output logic             decode_advance,
    output issue_packet_t    issue,
    output unit_vec_t        new_request,
    output id_t              issue_id,
    output alu_inputs_t      alu_inputs,
    output ls_inputs_t       ls_inputs,
    output branch_inputs_t   branch_inputs
);

    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::fn3_t      fn3;
    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::reg_addr_t rd_addr;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    unit_vec_t units_needed;
    logic stage_ready;
    logic forwarded_store;

    instr_decoder decoder_i (
        .instruction (decode.instruction),
        .opcode, .fn3, .rs1_addr, .rs2_addr, .rd_addr,
        .uses_rs1, .uses_rs2, .uses_rd, .units_needed
    );

    issue_control control_i (
        .clk, .rst, .flush, .decode,
        .opcode, .fn3, .rs1_addr, .rs2_addr, .rd_addr,
        .uses_rs1, .uses_rs2, .uses_rd, .units_needed,
        .rs_busy, .unit_ready,
        .issue, .decode_advance, .stage_ready, .new_request, .forwarded_store
    );

    unit_operand_prep prep_i (
        .clk, .stage_ready, .decode,
        .opcode, .fn3, .rs1_addr, .rd_addr,
        .issue, .rs_data, .forwarded_store, .rs2_busy_id,
        .alu_inputs, .ls_inputs, .branch_inputs
    );

    assign issue_id = issue.id;

endmodule

/* unit_operand_prep.sv */
////////////////////////////////////////////////////////////////////////////
// Operand preparation for the ALU, load/store and branch units.
// Values that depend only on the instruction and pc are registered with
// the stage register; register-file data is merged in the issue stage.
////////////////////////////////////////////////////////////////////////////

`include "rv_decode_defs.svh"

module unit_operand_prep
    import rv_isa_pkg::*;
    import issue_pkg::*;
(
    input  logic           clk,
    input  logic           stage_ready,
    input  decode_packet_t decode,
    input  opcode_t        opcode,
    input  fn3_t           fn3,
    input  reg_addr_t      rs1_addr,
    input  reg_addr_t      rd_addr,
    input  issue_packet_t  issue,
    input  word_t          rs_data [2],
    input  logic           forwarded_store,
    input  id_t            rs2_busy_id,
    output alu_inputs_t    alu_inputs,
    output ls_inputs_t     ls_inputs,
    output branch_inputs_t branch_inputs
);

    word_t instr;
    logic upper_op;
    logic sub_op;
    logic rs1_link;
    logic rd_link;
    word_t pre_in2;
    logic [20:0] pc_offset;
    alu_logic_op_t logic_op;

    // Registered in the issue stage
    word_t pre_in1_r;
    word_t pre_in2_r;
    logic rs1_use_rf;
    logic rs2_use_rf;
    alu_logic_op_t logic_op_r;
    logic subtract_r;
    logic lshift_r;
    logic shifter_path_r;
    logic slt_path_r;
    logic [11:0] ls_offset_r;
    logic load_r;
    logic store_r;
    logic [20:0] pc_offset_r;
    logic is_call_r;
    logic is_return_r;
    logic use_signed_r;

    word_t alu_rs1;
    word_t alu_rs2;

    assign instr = decode.instruction;

    // LUI, AUIPC, JAL and JALR all go through the adder
    assign upper_op = opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR};
    assign sub_op   = (opcode == OPC_OP) && (fn3 == FN3_ADD_SUB) && instr[30];

    ////////////////////////////////////////////////////////////////////////////
    // Decode-side preparation

    always_comb begin
        if (opcode inside {OPC_LUI, OPC_AUIPC}) begin
            pre_in2 = {instr[31:12], 12'b0};
        end else if (opcode inside {OPC_JAL, OPC_JALR}) begin
            pre_in2 = word_t'(4);
        end else begin
            pre_in2 = {{20{instr[31]}}, instr[31:20]};
        end
    end

    always_comb begin
        case (fn3)
            FN3_XOR: logic_op = ALU_LOGIC_XOR;
            FN3_OR:  logic_op = ALU_LOGIC_OR;
            FN3_AND: logic_op = ALU_LOGIC_AND;
            default: logic_op = ALU_LOGIC_ADD;
        endcase
        if (upper_op) begin
            logic_op = ALU_LOGIC_ADD;
        end
    end

    // JALR uses I format, JAL uses J format, branches use B format
    always_comb begin
        if (opcode == OPC_JALR) begin
            pc_offset = {{9{instr[31]}}, instr[31:20]};
        end else if (opcode == OPC_JAL) begin
            pc_offset = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        end else begin
            pc_offset = {{8{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        end
    end

    // x1 and x5 are link registers
    assign rs1_link = rs1_addr inside {5'd1, 5'd5};
    assign rd_link  = rd_addr inside {5'd1, 5'd5};

    always_ff @(posedge clk) begin
        if (stage_ready) begin
            pre_in1_r      <= (opcode inside {OPC_AUIPC, OPC_JAL, OPC_JALR}) ? decode.pc : '0;
            pre_in2_r      <= pre_in2;
            rs1_use_rf     <= ~upper_op;
            rs2_use_rf     <= (opcode == OPC_OP);
            logic_op_r     <= logic_op;
            subtract_r     <= ~upper_op & ((fn3 inside {FN3_SLT, FN3_SLTU}) | sub_op);
            lshift_r       <= ~fn3[2];
            shifter_path_r <= ~upper_op & (fn3 inside {FN3_SLL, FN3_SRL_SRA});
            slt_path_r     <= ~upper_op & (fn3 inside {FN3_SLT, FN3_SLTU});
            ls_offset_r    <= (opcode == OPC_STORE) ? {instr[31:25], instr[11:7]} : instr[31:20];
            load_r         <= (opcode == OPC_LOAD);
            store_r        <= (opcode == OPC_STORE);
            pc_offset_r    <= pc_offset;
            is_call_r      <= (opcode inside {OPC_JAL, OPC_JALR}) & rd_link;
            is_return_r    <= (opcode == OPC_JALR) & rs1_link & (~rd_link | (rs1_addr != rd_addr));
            use_signed_r   <= !(fn3 inside {FN3_BLTU, FN3_BGEU});
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue-side merge

    assign alu_rs1 = rs1_use_rf ? rs_data[0] : pre_in1_r;
    assign alu_rs2 = rs2_use_rf ? rs_data[1] : pre_in2_r;

    // fn3[0] marks the unsigned compare
    assign alu_inputs.in1          = {alu_rs1[`XLEN-1] & ~issue.fn3[0], alu_rs1};
    assign alu_inputs.in2          = {alu_rs2[`XLEN-1] & ~issue.fn3[0], alu_rs2};
    assign alu_inputs.shifter_in   = rs_data[0];
    assign alu_inputs.shift_amount =
        (issue.opcode == OPC_OP) ? rs_data[1][`REG_ADDR_W-1:0] : issue.rs2_addr;
    assign alu_inputs.logic_op     = logic_op_r;
    assign alu_inputs.subtract     = subtract_r;
    assign alu_inputs.arith        = alu_rs1[`XLEN-1] & issue.instruction[30];
    assign alu_inputs.lshift       = lshift_r;
    assign alu_inputs.shifter_path = shifter_path_r;
    assign alu_inputs.slt_path     = slt_path_r;

    assign ls_inputs.rs1              = rs_data[0];
    assign ls_inputs.rs2              = rs_data[1];
    assign ls_inputs.offset           = ls_offset_r;
    assign ls_inputs.fn3              = issue.fn3;
    assign ls_inputs.load             = load_r;
    assign ls_inputs.store            = store_r;
    assign ls_inputs.forwarded_store  = forwarded_store;
    assign ls_inputs.store_forward_id = rs2_busy_id;

    assign branch_inputs.rs1        = rs_data[0];
    assign branch_inputs.rs2        = rs_data[1];
    assign branch_inputs.issue_pc   = issue.pc;
    assign branch_inputs.pc_offset  = pc_offset_r;
    assign branch_inputs.fn3        = issue.fn3;
    assign branch_inputs.use_signed = use_signed_r;
    assign branch_inputs.jal        = (issue.opcode == OPC_JAL);
    assign branch_inputs.jalr       = (issue.opcode == OPC_JALR);
    assign branch_inputs.is_call    = is_call_r;
    assign branch_inputs.is_return  = is_return_r;

endmodule

/* issue_control.sv */
////////////////////////////////////////////////////////////////////////////
// Issue-stage register, hazard check and per-unit request strobes.
// Busy flags come from an outside scoreboard in the same cycle.
// An instruction issues only when every unit it needs is ready.
////////////////////////////////////////////////////////////////////////////

`include "rv_decode_defs.svh"

module issue_control
    import rv_isa_pkg::*;
    import issue_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  decode_packet_t decode,
    input  opcode_t        opcode,
    input  fn3_t           fn3,
    input  reg_addr_t      rs1_addr,
    input  reg_addr_t      rs2_addr,
    input  reg_addr_t      rd_addr,
    input  logic           uses_rs1,
    input  logic           uses_rs2,
    input  logic           uses_rd,
    input  unit_vec_t      units_needed,
    input  logic           rs_busy [2],
    input  unit_vec_t      unit_ready,
    output issue_packet_t  issue,
    output logic           decode_advance,
    output logic           stage_ready,
    output unit_vec_t      new_request,
    output logic           forwarded_store
);

    logic rs1_conflict;
    logic rs2_conflict;
    logic units_ok;
    logic operands_ok;
    logic issue_now;
    unit_vec_t unit_operands_ready;

    // Stage register, only stage_valid is cleared
    always_ff @(posedge clk) begin
        if (stage_ready) begin
            issue.pc          <= decode.pc;
            issue.instruction <= decode.instruction;
            issue.id          <= decode.id;
            issue.fn3         <= fn3;
            issue.opcode      <= opcode;
            issue.rs1_addr    <= rs1_addr;
            issue.rs2_addr    <= rs2_addr;
            issue.rd_addr     <= rd_addr;
            issue.uses_rs1    <= uses_rs1;
            issue.uses_rs2    <= uses_rs2;
            issue.uses_rd     <= uses_rd;
            issue.units       <= units_needed;
        end
        if (rst || flush) begin
            issue.stage_valid <= 1'b0;
        end else if (stage_ready) begin
            issue.stage_valid <= decode.valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hazards

    assign rs1_conflict = rs_busy[0] & issue.uses_rs1;
    assign rs2_conflict = rs_busy[1] & issue.uses_rs2;

    // Load/store can take its store data later through forwarding
    always_comb begin
        unit_operands_ready = {`NUM_UNITS{~rs1_conflict & ~rs2_conflict}};
        unit_operands_ready[`UNIT_LS] = ~rs1_conflict;
    end

    // Checked only over the units this instruction needs
    assign units_ok    = &(~issue.units | unit_ready);
    assign operands_ok = &(~issue.units | unit_operands_ready);

    ////////////////////////////////////////////////////////////////////////////
    // Issue

    assign issue_now   = issue.stage_valid & ~flush & units_ok & operands_ok;
    assign new_request = issue.units & {`NUM_UNITS{issue_now}};

    assign stage_ready    = ~issue.stage_valid | issue_now;
    assign decode_advance = decode.valid & stage_ready;

    assign forwarded_store = issue.units[`UNIT_LS] & rs2_conflict;

endmodule

/* instr_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// Field decode of one RV32I instruction, purely combinational.
// Opcodes outside the nine supported ones need no unit.
////////////////////////////////////////////////////////////////////////////

`include "rv_decode_defs.svh"

module instr_decoder
    import rv_isa_pkg::*;
    import issue_pkg::*;
(
    input  word_t     instruction,
    output opcode_t   opcode,
    output fn3_t      fn3,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output logic      uses_rd,
    output unit_vec_t units_needed
);

    // Field slices
    assign opcode   = opcode_t'(instruction[6:2]);
    assign fn3      = instruction[14:12];
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];
    assign rd_addr  = instruction[11:7];

    // U and J formats have no rs1, only R, S and B formats read rs2
    assign uses_rs1 = !(opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL});
    assign uses_rs2 = opcode inside {OPC_BRANCH, OPC_STORE, OPC_OP};
    assign uses_rd  = !(opcode inside {OPC_BRANCH, OPC_STORE});

    ////////////////////////////////////////////////////////////////////////////
    // Unit routing

    // Jumps write the link register through the ALU
    assign units_needed[`UNIT_ALU] =
        opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR};
    assign units_needed[`UNIT_BRANCH] = opcode inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
    assign units_needed[`UNIT_LS]     = opcode inside {OPC_LOAD, OPC_STORE};

endmodule

/* issue_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Packets between decode, the issue stage and the execution units.
// Unit input structs are only meaningful while their request strobe is high.
////////////////////////////////////////////////////////////////////////////

`include "rv_decode_defs.svh"

package issue_pkg;

    import rv_isa_pkg::*;

    typedef logic [`ID_W-1:0] id_t;
    typedef logic [`NUM_UNITS-1:0] unit_vec_t;

    // Presented by the fetch side
    typedef struct packed {
        logic valid;
        word_t pc;
        word_t instruction;
        id_t id;
    } decode_packet_t;

    // Held in the issue stage
    typedef struct packed {
        logic stage_valid;
        word_t pc;
        word_t instruction;
        id_t id;
        fn3_t fn3;
        opcode_t opcode;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        unit_vec_t units;
    } issue_packet_t;

    // Top bit of in1/in2 extends the sign for compares
    typedef struct packed {
        logic [`XLEN:0] in1;
        logic [`XLEN:0] in2;
        word_t shifter_in;
        reg_addr_t shift_amount;
        alu_logic_op_t logic_op;
        logic subtract;
        logic arith;
        logic lshift;
        logic shifter_path;
        logic slt_path;
    } alu_inputs_t;

    typedef struct packed {
        word_t rs1;
        word_t rs2;
        logic [11:0] offset;
        fn3_t fn3;
        logic load;
        logic store;
        logic forwarded_store;
        id_t store_forward_id;
    } ls_inputs_t;

    typedef struct packed {
        word_t rs1;
        word_t rs2;
        word_t issue_pc;
        logic [20:0] pc_offset;
        fn3_t fn3;
        logic use_signed;
        logic jal;
        logic jalr;
        logic is_call;
        logic is_return;
    } branch_inputs_t;

endpackage

/* rv_isa_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// RV32I base instruction set types only. No M, A, CSR or fence opcodes.
// Opcode values are bits [6:2] of the instruction word.
////////////////////////////////////////////////////////////////////////////

`include "rv_decode_defs.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [2:0] fn3_t;

    // Trimmed opcode field
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_t;

    // ALU fn3 codes
    localparam fn3_t FN3_ADD_SUB = 3'b000;
    localparam fn3_t FN3_SLL     = 3'b001;
    localparam fn3_t FN3_SLT     = 3'b010;
    localparam fn3_t FN3_SLTU    = 3'b011;
    localparam fn3_t FN3_XOR     = 3'b100;
    localparam fn3_t FN3_SRL_SRA = 3'b101;
    localparam fn3_t FN3_OR      = 3'b110;
    localparam fn3_t FN3_AND     = 3'b111;

    // Unsigned branch compares
    localparam fn3_t FN3_BLTU = 3'b110;
    localparam fn3_t FN3_BGEU = 3'b111;

    // ALU result path select
    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00,
        ALU_LOGIC_OR  = 2'b01,
        ALU_LOGIC_AND = 2'b10,
        ALU_LOGIC_ADD = 2'b11
    } alu_logic_op_t;

endpackage

/* rv_decode_defs.svh */
////////////////////////////////////////////////////////////////////////////
// Widths and unit indices shared by the decode and issue stage.
// Unit indices must stay below NUM_UNITS and be unique.
////////////////////////////////////////////////////////////////////////////

`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// Datapath
`define XLEN 32
`define REG_ADDR_W 5

// Instruction ids handed out by decode
`define ID_W 3

// Execution units
`define NUM_UNITS 3
`define UNIT_ALU 0
`define UNIT_BRANCH 1
`define UNIT_LS 2

`endif
